/* uartPkg.sv */
package uartPkg;

    // System clock and serial line rate.
    localparam int CLK_FREQ_HZ = 27_000_000;
    localparam int BAUD_RATE = 115_200;

    // Bit timing gives 234 clocks per bit at these rates.
    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    // Echo buffer depth must be a power of two.
    localparam int FIFO_DEPTH = 4;

    // Wide enough for CLKS_PER_BIT.
    typedef logic [7:0] bitCnt_t;

    typedef logic [7:0] byte_t;

endpackage

/* uartRx.sv */
`timescale 1ns/100ps

module uartRx import uartPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  rxLine,
    output byte_t rxData,
    output logic  rxValid,
    output logic  frameError
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_RECOVER
    } rxState_t;

    rxState_t state;
    bitCnt_t  cnt;
    logic [2:0] bitIdx;
    byte_t    dataBuf;

    // Two-stage synchronizer for the asynchronous serial input.
    logic rxMeta;
    logic rxSync;

    logic halfDone;
    logic bitDone;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rxLine;
            rxSync <= rxMeta;
        end
    end

    assign halfDone = (cnt == bitCnt_t'(HALF_BIT - 1));
    assign bitDone  = (cnt == bitCnt_t'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= RX_IDLE;
            cnt        <= '0;
            bitIdx     <= '0;
            rxValid    <= 1'b0;
            frameError <= 1'b0;
        end else begin
            rxValid    <= 1'b0;
            frameError <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rxSync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (halfDone) begin
                        cnt <= '0;
                        // Line back high at mid-start means a glitch.
                        if (rxSync) begin
                            state <= RX_IDLE;
                        end else begin
                            state  <= RX_DATA;
                            bitIdx <= '0;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bitDone) begin
                        cnt <= '0;
                        if (bitIdx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bitDone) begin
                        cnt <= '0;
                        if (rxSync) begin
                            rxValid <= 1'b1;
                            state   <= RX_IDLE;
                        end else begin
                            frameError <= 1'b1;
                            state      <= RX_RECOVER;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_RECOVER: begin
                    // Wait for idle line before hunting for a start bit.
                    cnt <= '0;
                    if (rxSync) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bitDone) begin
            dataBuf[bitIdx] <= rxSync;
        end
    end

    // Output holds the last good byte.
    always_ff @(posedge clk) begin
        if (state == RX_STOP && bitDone && rxSync) begin
            rxData <= dataBuf;
        end
    end

endmodule

/* byteFifo.sv */
`timescale 1ns/100ps

module byteFifo import uartPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  push,
    input  byte_t wrData,
    input  logic  pop,
    output byte_t rdData,
    output logic  empty
);

    typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] count_t;

    byte_t  mem [FIFO_DEPTH];
    ptr_t   wrPtr;
    ptr_t   rdPtr;
    count_t count;

    logic full;
    logic doPush;
    logic doPop;

    assign empty  = (count == '0);
    assign full   = (count == count_t'(FIFO_DEPTH));
    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    // Head entry is always visible.
    assign rdData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= wrData;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* uartTx.sv */
`timescale 1ns/100ps

module uartTx import uartPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  empty,
    input  byte_t txByte,
    output logic  pop,
    output logic  txLine
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } txState_t;

    txState_t state;
    bitCnt_t  cnt;
    logic [2:0] bitIdx;

    // Stop, data and start bits; bit 0 goes out first.
    logic [9:0] frame;

    logic bitDone;

    assign bitDone = (cnt == bitCnt_t'(CLKS_PER_BIT - 1));

    // Last stop-bit cycle may take the next byte, so frames run back to back.
    assign pop = !empty && (state == TX_IDLE || (state == TX_STOP && bitDone));

    always_ff @(posedge clk) begin
        if (pop) begin
            frame <= {1'b1, txByte, 1'b0};
        end else if (bitDone) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= TX_IDLE;
            cnt    <= '0;
            bitIdx <= '0;
            txLine <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (pop) begin
                        state  <= TX_START;
                        txLine <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bitDone) begin
                        cnt    <= '0;
                        bitIdx <= '0;
                        state  <= TX_DATA;
                        txLine <= frame[1];
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bitDone) begin
                        cnt    <= '0;
                        txLine <= frame[1];
                        if (bitIdx == 3'd7) begin
                            state <= TX_STOP;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bitDone) begin
                        cnt <= '0;
                        if (pop) begin
                            state  <= TX_START;
                            txLine <= 1'b0;
                        end else begin
                            state  <= TX_IDLE;
                            txLine <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state  <= TX_IDLE;
                    txLine <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* uartEcho.sv */
`timescale 1ns/100ps

module uartEcho import uartPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  rxLine,
    output logic  txLine,
    output byte_t rxData,
    output logic  rxValid,
    output logic  frameError
);

    // FIFO head and handshake to the transmitter.
    byte_t fifoData;
    logic  fifoEmpty;
    logic  txPop;

    uartRx rx_i (
        .clk        (clk),
        .arstN      (arstN),
        .rxLine     (rxLine),
        .rxData     (rxData),
        .rxValid    (rxValid),
        .frameError (frameError)
    );

    // Only good bytes are pushed for echo.
    byteFifo fifo_i (
        .clk    (clk),
        .arstN  (arstN),
        .push   (rxValid),
        .wrData (rxData),
        .pop    (txPop),
        .rdData (fifoData),
        .empty  (fifoEmpty)
    );

    uartTx tx_i (
        .clk    (clk),
        .arstN  (arstN),
        .empty  (fifoEmpty),
        .txByte (fifoData),
        .pop    (txPop),
        .txLine (txLine)
    );

endmodule

/* tbClock.sv */
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic arstN
);

    // 100 MHz simulation clock.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for the first 10 cycles.
    initial begin
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

/* uartEchoTb.sv */
`timescale 1ns/100ps

module uartEchoTb import uartPkg::*; ();

    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    localparam int NUM_FRAMES = 16;
    // About 60 percent margin over the expected frame count.
    localparam int TIMEOUT_CYCLES = (NUM_FRAMES * FRAME_CYCLES * 8) / 5;

    logic  clk;
    logic  arstN;
    logic  rxLine;
    logic  txLine;
    byte_t rxData;
    logic  rxValid;
    logic  frameError;

    // Expected results and decoded echoes.
    byte_t expRx[$];
    byte_t expEcho[$];
    byte_t echoQ[$];
    int    expErrors = 0;

    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;

    tbClock clkGen_i (
        .clk   (clk),
        .arstN (arstN)
    );

    uartEcho dut_i (
        .clk        (clk),
        .arstN      (arstN),
        .rxLine     (rxLine),
        .txLine     (txLine),
        .rxData     (rxData),
        .rxValid    (rxValid),
        .frameError (frameError)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bit 8 set means a good byte that is reported and echoed.
    function automatic logic [8:0] expectedOutcome(input byte_t value, input logic stopBit);
        if (stopBit) begin
            return {1'b1, value};
        end else begin
            return 9'h000;
        end
    endfunction

    // One 8N1 frame on rxLine with the LSB first.
    task automatic sendFrame(input byte_t value, input logic stopBit);
        logic [9:0] bits;
        bits = {stopBit, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rxLine <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic sendAndExpect(input byte_t value, input logic stopBit);
        logic [8:0] outcome;
        outcome = expectedOutcome(value, stopBit);
        if (outcome[8]) begin
            expRx.push_back(outcome[7:0]);
            expEcho.push_back(outcome[7:0]);
        end else begin
            expErrors++;
        end
        sendFrame(value, stopBit);
    endtask

    task automatic waitForExpected(input logic includeEcho);
        while (expRx.size() != 0 || expErrors != 0 ||
               (includeEcho && expEcho.size() != 0)) begin
            @(negedge clk);
        end
    endtask

    task automatic checkIdleOutputs();
        if (txLine !== 1'b1) begin
            $display("MISMATCH at %0t: txLine is %b, expected 1", $time, txLine);
            errorCount++;
        end
        if (rxValid !== 1'b0) begin
            $display("MISMATCH at %0t: rxValid is %b, expected 0", $time, rxValid);
            errorCount++;
        end
        if (frameError !== 1'b0) begin
            $display("MISMATCH at %0t: frameError is %b, expected 0", $time, frameError);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("[%0t] %s: PASS", $time, name);
        end else begin
            failCount++;
            $display("[%0t] %s: FAIL with %0d errors", $time, name, errorCount - errorsBefore);
        end
    endtask

    // Decodes echoed frames at mid-bit.
    initial begin : decodeTx
        byte_t value;
        logic  prevTx;
        prevTx = 1'b1;
        forever begin
            @(negedge clk);
            if (prevTx === 1'b1 && txLine === 1'b0) begin
                repeat (HALF_BIT) @(negedge clk);
                if (txLine !== 1'b0) begin
                    $display("MISMATCH at %0t: start bit on txLine is %b, expected 0",
                             $time, txLine);
                    errorCount++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    value[i] = txLine;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (txLine !== 1'b1) begin
                    $display("MISMATCH at %0t: stop bit on txLine is %b, expected 1",
                             $time, txLine);
                    errorCount++;
                end
                echoQ.push_back(value);
            end
            prevTx = txLine;
        end
    end

    always @(negedge clk) begin : compareOutputs
        byte_t expected;
        byte_t got;
        if (arstN) begin
            if (rxValid === 1'b1 && frameError === 1'b1) begin
                $display("ERROR at %0t: rxValid and frameError pulsed together", $time);
                errorCount++;
            end
            if (rxValid === 1'b1) begin
                if (expRx.size() == 0) begin
                    $display("ERROR at %0t: rxValid pulsed with no byte expected", $time);
                    errorCount++;
                end else begin
                    expected = expRx.pop_front();
                    if (rxData !== expected) begin
                        $display("MISMATCH at %0t: rxData %02h, expected %02h",
                                 $time, rxData, expected);
                        errorCount++;
                    end
                end
            end
            if (frameError === 1'b1) begin
                if (expErrors == 0) begin
                    $display("ERROR at %0t: frameError pulsed on a good frame", $time);
                    errorCount++;
                end else begin
                    expErrors--;
                end
            end
            while (echoQ.size() > 0) begin
                got = echoQ.pop_front();
                if (expEcho.size() == 0) begin
                    $display("ERROR at %0t: echo of %02h with no echo expected", $time, got);
                    errorCount++;
                end else begin
                    expected = expEcho.pop_front();
                    if (got !== expected) begin
                        $display("MISMATCH at %0t: echo %02h, expected %02h",
                                 $time, got, expected);
                        errorCount++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin : runTests
        int          startErrors;
        logic [31:0] lcgState;
        byte_t       value;

        rxLine = 1'b1;
        lcgState = 32'he11b_145c;

        startErrors = errorCount;
        while (arstN !== 1'b1) begin
            @(negedge clk);
            checkIdleOutputs();
        end
        repeat (5) begin
            @(negedge clk);
            checkIdleOutputs();
        end
        reportTest("reset state", startErrors);

        startErrors = errorCount;
        sendAndExpect(8'hA5, 1'b1);
        waitForExpected(1'b0);
        reportTest("single byte", startErrors);

        startErrors = errorCount;
        waitForExpected(1'b1);
        reportTest("single echo", startErrors);

        startErrors = errorCount;
        for (int i = 0; i < 12; i++) begin
            lcgState = lcgNext(lcgState);
            value = lcgState[23:16];
            sendAndExpect(value, 1'b1);
        end
        waitForExpected(1'b1);
        reportTest("burst of 12", startErrors);

        startErrors = errorCount;
        sendAndExpect(8'h3C, 1'b0);
        // Line back to idle before the next frame.
        @(posedge clk);
        rxLine <= 1'b1;
        repeat (2 * CLKS_PER_BIT) @(posedge clk);
        waitForExpected(1'b0);
        sendAndExpect(8'h5A, 1'b1);
        waitForExpected(1'b1);
        reportTest("framing error", startErrors);

        $display("Summary: %0d passed, %0d failed, %0d errors",
                 passCount, failCount, errorCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
uartPkg.sv
uartRx.sv
byteFifo.sv
uartTx.sv
uartEcho.sv
tbClock.sv
uartEchoTb.sv
